// ==== flist.f ====
cpu_pkg.sv
cpu_alu.sv
cpu_decode.sv
cpu_sequencer.sv
cpu_datapath.sv
cpu_core.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
DUT_TOP   ?= cpu_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FLIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		--top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] reset_pc   = 16'h0400;      // Program start
    localparam int          num_random = 300;           // Random instructions after the prologue
    localparam int          run_limit  = 4000;          // Cycles allowed for all stores
    localparam int          tail_limit = 200;           // Cycles allowed to leave the program

    localparam logic [7:0] gen_ops [0:25] = '{
        8'ha9, 8'ha2, 8'ha0,                            // LDA LDX LDY
        8'h69, 8'he9, 8'h29, 8'h09, 8'h49,              // ADC SBC AND ORA EOR
        8'hc9, 8'he0, 8'hc0,                            // CMP CPX CPY
        8'h0a, 8'h4a, 8'h2a, 8'h6a,                     // ASL LSR ROL ROR
        8'haa, 8'h8a, 8'ha8, 8'h98,                     // TAX TXA TAY TYA
        8'he8, 8'hca, 8'hc8, 8'h88,                     // INX DEX INY DEY
        8'h18, 8'h38, 8'hea                             // CLC SEC NOP
    };
    localparam logic [7:0] store_ops [0:2] = '{8'h85, 8'h86, 8'h84};  // STA STX STY

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  data_in = 8'h00;
    logic [7:0]  data_out;
    logic        we;
    logic [7:0]  mem [0:65535];                         // 64 KiB memory
    logic [7:0]  rd_data = 8'h00;                       // Read register
    logic [31:0] rng;
    logic [15:0] prog_pc;                               // Next free program byte
    logic [7:0]  m_a;                                   // Model registers
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    logic [4:0]  op_idx;
    logic [1:0]  st_idx;
    int          num_stores;
    int          writes;
    int          check_errors;
    int          tb_errors;
    int          cycles;

    tb_clock #(.reset_cycles(16)) i_clock (.clk(clk), .reset(reset));

    cpu_core #(
        .reset_pc (reset_pc)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .we       (we)
    );

    tb_checker #(
        .reset_pc (reset_pc)
    ) i_checker (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .data_out (data_out),
        .we       (we),
        .writes   (writes),
        .errors   (check_errors)
    );

    always @(posedge clk) begin
        rd_data <= mem[addr];                           // Byte for this cycle's address
        if (we) begin
            mem[addr] = data_out;
        end
    end

    always @(negedge clk) begin
        data_in <= rd_data;                             // Shows up one cycle after the address
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic has_operand(input logic [7:0] op);
        return op inside {8'ha9, 8'ha2, 8'ha0, 8'h69, 8'he9, 8'h29, 8'h09, 8'h49,
                          8'hc9, 8'he0, 8'hc0, 8'h85, 8'h86, 8'h84};
    endfunction

    // 6502 behaviour in binary mode, C only
    task automatic model_step(input logic [7:0] op, input logic [7:0] imm);
        logic [8:0] sum;
        case (op)
            8'ha9: m_a = imm;
            8'ha2: m_x = imm;
            8'ha0: m_y = imm;
            8'h69: begin
                sum = {1'b0, m_a} + {1'b0, imm} + {8'd0, m_c};
                m_a = sum[7:0];
                m_c = sum[8];
            end
            8'he9: begin
                sum = {1'b0, m_a} - {1'b0, imm} - {8'd0, !m_c};   // Borrow is not C
                m_a = sum[7:0];
                m_c = !sum[8];
            end
            8'h29: m_a = m_a & imm;
            8'h09: m_a = m_a | imm;
            8'h49: m_a = m_a ^ imm;
            8'hc9: m_c = (m_a >= imm);
            8'he0: m_c = (m_x >= imm);
            8'hc0: m_c = (m_y >= imm);
            8'h0a: {m_c, m_a} = {m_a, 1'b0};
            8'h4a: {m_a, m_c} = {1'b0, m_a};
            8'h2a: {m_c, m_a} = {m_a, m_c};               // Nine-bit rotate through C
            8'h6a: {m_a, m_c} = {m_c, m_a};
            8'haa: m_x = m_a;
            8'h8a: m_a = m_x;
            8'ha8: m_y = m_a;
            8'h98: m_a = m_y;
            8'he8: m_x = m_x + 8'd1;
            8'hca: m_x = m_x - 8'd1;
            8'hc8: m_y = m_y + 8'd1;
            8'h88: m_y = m_y - 8'd1;
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'h85: i_checker.expect_write({8'h00, imm}, m_a);
            8'h86: i_checker.expect_write({8'h00, imm}, m_x);
            8'h84: i_checker.expect_write({8'h00, imm}, m_y);
            default: ;                                  // NOP
        endcase
        if (op inside {8'h85, 8'h86, 8'h84}) begin
            num_stores++;
        end
    endtask

    task automatic emit(input logic [7:0] op, input logic [7:0] operand);
        mem[prog_pc] = op;
        prog_pc = prog_pc + 16'd1;
        if (has_operand(op)) begin
            mem[prog_pc] = operand;
            prog_pc = prog_pc + 16'd1;
        end
        model_step(op, operand);
    endtask

    task automatic build_program();
        rng = xorshift32(rng);
        emit(8'ha9, rng[7:0]);                          // Registers and C known before use
        emit(8'ha2, rng[15:8]);
        emit(8'ha0, rng[23:16]);
        emit(8'h18, 8'h00);
        for (int n = 0; n < num_random; n++) begin
            rng = xorshift32(rng);
            op_idx = 5'(rng[15:8] % 8'd26);
            st_idx = 2'(rng[17:16] % 2'd3);
            if (rng[1:0] == 2'b00) begin                // One in four is a store
                emit(store_ops[st_idx], rng[31:24]);
            end else begin
                emit(gen_ops[op_idx], rng[31:24]);
            end
        end
    endtask

    initial begin
        rng        = 32'd68912;
        num_stores = 0;
        tb_errors  = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]] = (i < 256) ? (i[7:0] ^ 8'h3c) : 8'hea;  // Zero page pattern, NOP
        end
        prog_pc = reset_pc;
        build_program();

        cycles = 0;
        while (writes < num_stores && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (writes < num_stores) begin
            $display("Timeout: only %0d of %0d stores written after %0d cycles",
                     writes, num_stores, cycles);
            tb_errors++;
        end

        cycles = 0;                                     // Run into the NOP tail
        while (int'(addr) < int'(prog_pc) + 8 && cycles < tail_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (int'(addr) < int'(prog_pc) + 8) begin
            $display("Timeout: the fetch address never moved past the end of the program");
            tb_errors++;
        end

        if (writes != num_stores) begin
            $display("FAIL writes: got 0x%h expected 0x%h", writes, num_stores);
            tb_errors++;
        end
        $display("Stores %0d, writes %0d, checker errors %0d, testbench errors %0d",
                 num_stores, writes, check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
module tb_checker #(
    parameter logic [15:0] reset_pc = 16'h0000          // First opcode address
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] addr,
    input  logic [7:0]  data_out,
    input  logic        we,
    output int          writes,                         // Writes seen so far
    output int          errors                          // Mismatches seen so far
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] exp_addr [$];                          // Expected store addresses, in order
    logic [7:0]  exp_data [$];                          // Expected store data
    logic [15:0] last_pc   = reset_pc;
    logic        pc_seen   = 1'b0;                      // First fetch after reset not seen yet
    int          cycle_cnt = 0;
    int          write_cnt = 0;
    int          error_cnt = 0;

    assign writes = write_cnt;
    assign errors = error_cnt;

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic check_write();
        logic [15:0] ea;
        logic [7:0]  ed;
        write_cnt++;
        if (addr[15:8] != cpu_pkg::zero_page) begin
            $display("FAIL addr: write at 0x%h is outside zero page", addr);
            error_cnt++;
        end
        if (exp_addr.size() == 0) begin
            $display("Write of 0x%h to 0x%h with no store left to expect", data_out, addr);
            error_cnt++;
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (addr != ea) begin
                $display("FAIL addr: got 0x%h expected 0x%h", addr, ea);
                error_cnt++;
            end
            if (data_out != ed) begin
                $display("FAIL data_out: got 0x%h expected 0x%h (addr 0x%h)",
                         data_out, ed, ea);
                error_cnt++;
            end
        end
    endtask

    // Bus sampled on the rising edge, ahead of the DUT flops
    always @(posedge clk) begin
        if (reset) begin
            if (cycle_cnt > 0 && we) begin              // First edge may precede the reset
                $display("FAIL we: got 0x%h expected 0x0 during reset", we);
                error_cnt++;
            end
            if (cycle_cnt > 0 && addr != reset_pc) begin
                $display("FAIL addr: got 0x%h expected 0x%h during reset", addr, reset_pc);
                error_cnt++;
            end
        end else if (we) begin
            check_write();
        end else if (addr[15:8] != cpu_pkg::zero_page) begin
            // Program addresses step up by at most one byte per cycle
            if (!pc_seen && addr != reset_pc) begin
                $display("FAIL addr: got 0x%h expected 0x%h at first fetch", addr, reset_pc);
                error_cnt++;
            end else if (pc_seen && addr != last_pc && addr != last_pc + 16'd1) begin
                $display("FAIL addr: got 0x%h expected 0x%h or 0x%h",
                         addr, last_pc, last_pc + 16'd1);
                error_cnt++;
            end
            pc_seen = 1'b1;
            last_pc = addr;
        end
        cycle_cnt++;
    end

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
    parameter int reset_cycles = 16                     // Clock cycles held in reset
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                         // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clk);           // Released on a falling edge
        reset = 1'b0;
    end

endmodule

// ==== cpu_core.sv ====
module cpu_core #(
    parameter logic [cpu_pkg::addr_width-1:0] reset_pc = 16'h0400   // Start address
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic [cpu_pkg::addr_width-1:0]  addr,
    input  logic [cpu_pkg::data_width-1:0]  data_in,     // Byte at previous cycle's addr
    output logic [cpu_pkg::data_width-1:0]  data_out,
    output logic                            we
);

    cpu_pkg::state_t                 state;
    logic                            store;
    logic                            load_reg;
    logic                            load_only;
    logic                            shift;
    logic                            shift_right;
    logic                            rotate;
    logic                            inc;
    logic                            compare;
    logic                            carry_in_use;
    logic                            clc;
    logic                            sec;
    cpu_pkg::reg_sel_t               src_reg;
    cpu_pkg::reg_sel_t               dst_reg;
    cpu_pkg::alu_op_t                alu_op;
    logic [cpu_pkg::data_width-1:0]  store_data;

    cpu_sequencer #(
        .reset_pc   (reset_pc)
    ) u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .store      (store),
        .store_data (store_data),
        .state      (state),
        .addr       (addr),
        .data_out   (data_out),
        .we         (we)
    );

    cpu_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .data_in      (data_in),
        .store        (store),
        .load_reg     (load_reg),
        .load_only    (load_only),
        .shift        (shift),
        .shift_right  (shift_right),
        .rotate       (rotate),
        .inc          (inc),
        .compare      (compare),
        .carry_in_use (carry_in_use),
        .clc          (clc),
        .sec          (sec),
        .src_reg      (src_reg),
        .dst_reg      (dst_reg),
        .alu_op       (alu_op)
    );

    cpu_datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .data_in      (data_in),
        .load_only    (load_only),
        .src_reg      (src_reg),
        .dst_reg      (dst_reg),
        .alu_op       (alu_op),
        .shift_right  (shift_right),
        .rotate       (rotate),
        .shift        (shift),
        .inc          (inc),
        .compare      (compare),
        .carry_in_use (carry_in_use),
        .load_reg     (load_reg),
        .clc          (clc),
        .sec          (sec),
        .store_data   (store_data)
    );

endmodule

// ==== cpu_datapath.sv ====
module cpu_datapath (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::state_t                 state,
    input  logic [cpu_pkg::data_width-1:0]  data_in,       // Immediate operand in fetch
    input  logic                            load_only,
    input  cpu_pkg::reg_sel_t               src_reg,
    input  cpu_pkg::reg_sel_t               dst_reg,
    input  cpu_pkg::alu_op_t                alu_op,
    input  logic                            shift_right,
    input  logic                            rotate,
    input  logic                            shift,
    input  logic                            inc,
    input  logic                            compare,
    input  logic                            carry_in_use,
    input  logic                            load_reg,
    input  logic                            clc,
    input  logic                            sec,
    output logic [cpu_pkg::data_width-1:0]  store_data
);

    logic [cpu_pkg::data_width-1:0] reg_a;
    logic [cpu_pkg::data_width-1:0] reg_x;
    logic [cpu_pkg::data_width-1:0] reg_y;
    cpu_pkg::reg_sel_t              reg_sel;           // Read and write index
    logic [cpu_pkg::data_width-1:0] reg_out;
    logic [cpu_pkg::data_width-1:0] ai;
    logic [cpu_pkg::data_width-1:0] bi;
    logic                           ci;
    cpu_pkg::alu_op_t               op;
    logic                           right;
    logic [cpu_pkg::data_width-1:0] alu_result;
    logic                           alu_co;
    logic                           carry;              // C flag

    // Decode retires into the destination, other states read the source
    assign reg_sel = (state == cpu_pkg::state_decode) ? dst_reg : src_reg;

    always_comb begin
        case (reg_sel)
            cpu_pkg::sel_x: reg_out = reg_x;
            cpu_pkg::sel_y: reg_out = reg_y;
            default:        reg_out = reg_a;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
        end else if (state == cpu_pkg::state_decode && load_reg) begin
            case (reg_sel)
                cpu_pkg::sel_x: reg_x <= alu_result;
                cpu_pkg::sel_y: reg_y <= alu_result;
                default:        reg_a <= alu_result;
            endcase
        end
    end

    always_comb begin
        ai    = '0;                                     // Idle in decode and zp0
        bi    = '0;
        ci    = 1'b0;
        op    = cpu_pkg::op_add;
        right = 1'b0;
        case (state)
            cpu_pkg::state_fetch: begin
                ai    = load_only ? '0 : reg_out;       // Loads are 0 + operand
                bi    = data_in;
                ci    = compare   ? 1'b1 :              // Compare is a borrow-free subtract
                        load_only ? 1'b0 : carry;
                op    = alu_op;
            end
            cpu_pkg::state_reg: begin
                ai    = reg_out;
                bi    = '0;
                ci    = rotate ? carry :
                        shift  ? 1'b0 : inc;            // INX/INY add one
                op    = alu_op;
                right = shift_right;
            end
            default: ;
        endcase
    end

    cpu_alu u_alu (
        .clk    (clk),
        .reset  (reset),
        .op     (op),
        .right  (right),
        .ai     (ai),
        .bi     (bi),
        .ci     (ci),
        .result (alu_result),
        .co     (alu_co)
    );

    // Carry settles when the instruction retires
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            carry <= 1'b0;
        end else if (state == cpu_pkg::state_decode) begin
            if (carry_in_use | shift | compare) begin
                carry <= alu_co;
            end else if (sec) begin
                carry <= 1'b1;
            end else if (clc) begin
                carry <= 1'b0;
            end
        end
    end

    assign store_data = reg_out;                        // Source register in zp0

endmodule

// ==== cpu_sequencer.sv ====
module cpu_sequencer #(
    parameter logic [cpu_pkg::addr_width-1:0] reset_pc = '0  // First opcode address
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpu_pkg::data_width-1:0]  data_in,
    input  logic                            store,       // Current instruction is a store
    input  logic [cpu_pkg::data_width-1:0]  store_data,  // Register to be written
    output cpu_pkg::state_t                 state,
    output logic [cpu_pkg::addr_width-1:0]  addr,
    output logic [cpu_pkg::data_width-1:0]  data_out,
    output logic                            we
);

    cpu_pkg::state_t                 next_state;
    logic [cpu_pkg::addr_width-1:0]  pc;
    logic                            pc_inc;

    always_comb begin
        next_state = cpu_pkg::state_decode;
        pc_inc     = 1'b0;
        case (state)
            cpu_pkg::state_decode: begin
                case (data_in)                      // Opcode class
                    8'h84, 8'h85, 8'h86:
                        next_state = cpu_pkg::state_zp0;    // Zero page stores
                    8'h09, 8'h29, 8'h49, 8'h69, 8'ha9, 8'hc9, 8'he9,
                    8'ha0, 8'ha2, 8'hc0, 8'he0:
                        next_state = cpu_pkg::state_fetch;  // Immediates
                    default:
                        next_state = cpu_pkg::state_reg;    // Everything else, unknowns too
                endcase
                // Register ops re-read the byte after the opcode as the next opcode
                pc_inc = (next_state != cpu_pkg::state_reg);
            end
            cpu_pkg::state_fetch: begin
                next_state = cpu_pkg::state_decode;
                pc_inc     = 1'b1;
            end
            cpu_pkg::state_reg: begin
                next_state = cpu_pkg::state_decode;
                pc_inc     = 1'b1;
            end
            cpu_pkg::state_zp0: begin
                next_state = cpu_pkg::state_fetch;          // PC already on next opcode
                pc_inc     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::state_fetch;                  // Fetch opcode at reset_pc first
            pc    <= reset_pc;
        end else begin
            state <= next_state;
            pc    <= pc + {{(cpu_pkg::addr_width-1){1'b0}}, pc_inc};
        end
    end

    // Operand byte is the zero page address during zp0
    assign addr = (state == cpu_pkg::state_zp0) ? {cpu_pkg::zero_page, data_in} : pc;

    assign we       = (state == cpu_pkg::state_zp0) && store;
    assign data_out = store_data;

endmodule

// ==== cpu_decode.sv ====
module cpu_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::state_t                 state,
    input  logic [cpu_pkg::data_width-1:0]  data_in,       // Opcode during decode
    output logic                            store,         // STA, STX, STY
    output logic                            load_reg,      // Result goes to register file
    output logic                            load_only,     // LDA, LDX, LDY
    output logic                            shift,         // Any accumulator shift
    output logic                            shift_right,   // LSR, ROR
    output logic                            rotate,        // ROL, ROR
    output logic                            inc,           // INX, INY
    output logic                            compare,       // CMP, CPX, CPY
    output logic                            carry_in_use,  // ADC, SBC
    output logic                            clc,
    output logic                            sec,
    output cpu_pkg::reg_sel_t               src_reg,
    output cpu_pkg::reg_sel_t               dst_reg,
    output cpu_pkg::alu_op_t                alu_op
);

    // Flags held from one decode to the next
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            store        <= 1'b0;
            load_reg     <= 1'b0;
            load_only    <= 1'b0;
            shift        <= 1'b0;
            shift_right  <= 1'b0;
            rotate       <= 1'b0;
            inc          <= 1'b0;
            compare      <= 1'b0;
            carry_in_use <= 1'b0;
            clc          <= 1'b0;
            sec          <= 1'b0;
            src_reg      <= cpu_pkg::sel_a;
            dst_reg      <= cpu_pkg::sel_a;
            alu_op       <= cpu_pkg::op_add;
        end else if (state == cpu_pkg::state_decode) begin
            store        <= data_in inside {8'h84, 8'h85, 8'h86};
            load_reg     <= data_in inside {8'ha9, 8'ha2, 8'ha0,           // Loads
                                            8'h69, 8'he9, 8'h29, 8'h09, 8'h49,
                                            8'h0a, 8'h2a, 8'h4a, 8'h6a,    // Shifts
                                            8'haa, 8'h8a, 8'ha8, 8'h98,    // Transfers
                                            8'he8, 8'hca, 8'hc8, 8'h88};   // Counters
            load_only    <= data_in inside {8'ha9, 8'ha2, 8'ha0};
            shift        <= data_in inside {8'h0a, 8'h2a, 8'h4a, 8'h6a};
            shift_right  <= data_in inside {8'h4a, 8'h6a};
            rotate       <= data_in inside {8'h2a, 8'h6a};
            inc          <= data_in inside {8'he8, 8'hc8};
            compare      <= data_in inside {8'hc9, 8'he0, 8'hc0};
            carry_in_use <= data_in inside {8'h69, 8'he9};
            clc          <= (data_in == 8'h18);
            sec          <= (data_in == 8'h38);

            case (data_in)
                8'h8a, 8'he0, 8'he8, 8'hca, 8'h86: src_reg <= cpu_pkg::sel_x;  // TXA CPX INX DEX STX
                8'h98, 8'hc0, 8'hc8, 8'h88, 8'h84: src_reg <= cpu_pkg::sel_y;  // TYA CPY INY DEY STY
                default:                           src_reg <= cpu_pkg::sel_a;
            endcase

            case (data_in)
                8'ha2, 8'haa, 8'he8, 8'hca: dst_reg <= cpu_pkg::sel_x;    // LDX TAX INX DEX
                8'ha0, 8'ha8, 8'hc8, 8'h88: dst_reg <= cpu_pkg::sel_y;    // LDY TAY INY DEY
                default:                    dst_reg <= cpu_pkg::sel_a;
            endcase

            case (data_in)
                8'h0a, 8'h2a:               alu_op <= cpu_pkg::op_rol;    // ASL, ROL
                8'h4a, 8'h6a:               alu_op <= cpu_pkg::op_pass;   // LSR, ROR
                8'he9, 8'hc9, 8'he0, 8'hc0,
                8'hca, 8'h88:               alu_op <= cpu_pkg::op_sub;    // SBC, compares, DEX, DEY
                8'h29:                      alu_op <= cpu_pkg::op_and;
                8'h09:                      alu_op <= cpu_pkg::op_or;
                8'h49:                      alu_op <= cpu_pkg::op_eor;
                default:                    alu_op <= cpu_pkg::op_add;    // Loads, ADC, moves, INX
            endcase
        end
    end

endmodule

// ==== cpu_alu.sv ====
module cpu_alu (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::alu_op_t                op,         // Operation for this cycle
    input  logic                            right,      // Shift A input right
    input  logic [cpu_pkg::data_width-1:0]  ai,
    input  logic [cpu_pkg::data_width-1:0]  bi,
    input  logic                            ci,         // Carry in
    output logic [cpu_pkg::data_width-1:0]  result,     // Registered result
    output logic                            co          // Registered carry out
);

    logic [cpu_pkg::data_width-1:0] logic_out;          // Logic stage, first adder term
    logic [cpu_pkg::data_width-1:0] b_term;             // Second adder term
    logic                           adder_ci;
    logic [cpu_pkg::data_width:0]   sum;                // One extra bit for carry

    always_comb begin
        case (op[1:0])
            2'b00:   logic_out = ai | bi;
            2'b01:   logic_out = ai & bi;
            2'b10:   logic_out = ai ^ bi;
            default: logic_out = ai;                    // Arithmetic and pass
        endcase
        if (right) begin
            logic_out = {ci, ai[cpu_pkg::data_width-1:1]};  // Carry enters at bit 7
        end
    end

    always_comb begin
        case (op[3:2])
            2'b00:   b_term = bi;                       // Add
            2'b01:   b_term = ~bi;                      // Subtract
            2'b10:   b_term = logic_out;                // Doubling, rotate left
            default: b_term = '0;                       // Logic ops and pass
        endcase
    end

    // No carry into logic results or right shifts
    assign adder_ci = (right || op[3:2] == 2'b11) ? 1'b0 : ci;

    assign sum = {1'b0, logic_out} + {1'b0, b_term}
               + {{cpu_pkg::data_width{1'b0}}, adder_ci};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            co     <= 1'b0;
        end else begin
            result <= sum[cpu_pkg::data_width-1:0];
            co     <= right ? ai[0] : sum[cpu_pkg::data_width];  // Bit 0 falls out on LSR/ROR
        end
    end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_width = 8;                          // Data bus and register width
    localparam int addr_width = 16;                         // Address bus width
    localparam logic [data_width-1:0] zero_page = 8'h00;    // High byte of zero page

    // Sequencer states, one per kept addressing path
    typedef enum logic [1:0] {
        state_decode,                                       // Opcode on read bus, retire previous
        state_fetch,                                        // Immediate operand, next opcode
        state_reg,                                          // Register-only operation
        state_zp0                                           // Zero page store
    } state_t;

    // ALU ops, bits [3:2] pick the B term and bits [1:0] the logic function
    typedef enum logic [3:0] {
        op_or   = 4'b1100,                                  // A | B
        op_and  = 4'b1101,                                  // A & B
        op_eor  = 4'b1110,                                  // A ^ B
        op_add  = 4'b0011,                                  // A + B + C
        op_sub  = 4'b0111,                                  // A + ~B + C
        op_rol  = 4'b1011,                                  // A + A + C
        op_pass = 4'b1111                                   // A, also used for right shifts
    } alu_op_t;

    // Register file index
    typedef enum logic [1:0] {
        sel_a,                                              // Accumulator
        sel_x,                                              // X index
        sel_y                                               // Y index
    } reg_sel_t;

endpackage
